/* files.f */
cpuPkg.sv
instructionLoader.sv
internalDataflow.sv
sequencer.sv
top8227.sv
tbTop8227.sv

/* tbTop8227.sv */
`timescale 1ns/10ps

module tbTop8227;
    import cpuPkg::*;

    localparam int          NUM_INSTR  = 200;
    localparam int          CLK_PERIOD = 8;
    localparam int          TIMEOUT_NS = (NUM_INSTR * 4 + 40) * CLK_PERIOD;
    localparam logic [31:0] SEED       = 32'h10b9_9472;
    localparam logic [15:0] DATA_BASE  = 16'h8000; // STA targets, clear of the code.

    logic       clk;
    logic       rst;
    wire  [7:0] dataBusGPIO;
    logic [7:0] AddressBusHigh;
    logic [7:0] AddressBusLow;
    logic       readNotWrite;

    logic [7:0]  mem [0:65535];
    logic [15:0] busAddress;

    // Expected bus access for every cycle after reset.
    logic [15:0] expAddr[$];
    bit          expWrite[$];
    logic [7:0]  expData[$];

    int errors;
    int checks;

    top8227 u_top8227 (
        .clk(clk),
        .rst(rst),
        .dataBusGPIO(dataBusGPIO),
        .AddressBusHigh(AddressBusHigh),
        .AddressBusLow(AddressBusLow),
        .readNotWrite(readNotWrite)
    );

    assign busAddress  = {AddressBusHigh, AddressBusLow};
    assign dataBusGPIO = (readNotWrite === 1'b0) ? 'z : mem[busAddress]; // Async read.

    always @(posedge clk) begin
        if (readNotWrite === 1'b0) begin
            mem[busAddress] <= dataBusGPIO;
        end
    end

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check(input string name, input logic [15:0] expected,
                         input logic [15:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error: %s expected %h, got %h at %0t ns", name, expected, actual, $time);
        end
    endtask

    task automatic expectAccess(input logic [15:0] addr, input bit isWrite,
                                input logic [7:0] data);
        expAddr.push_back(addr);
        expWrite.push_back(isWrite);
        expData.push_back(data);
    endtask

    // Puts a code byte in memory and expects it to be read.
    task automatic codeRead(input logic [15:0] addr, input logic [7:0] value);
        mem[addr] = value;
        expectAccess(addr, 1'b0, 8'h00);
    endtask

    // Random program plus the reference model of its bus traffic.
    task automatic buildProgram();
        logic [15:0] pc;
        logic [15:0] target;
        logic [15:0] fillAddr;
        logic [7:0]  acc;
        logic [7:0]  imm;
        logic [8:0]  sum;
        logic        carry;
        logic [7:0]  oddOps [4];
        int          pick;
        oddOps = '{8'h02, 8'h00, 8'hFF, 8'h8A};
        for (int a = 0; a < 65536; a++) begin
            fillAddr = 16'(a);
            mem[a]   = fillAddr[15:8] ^ fillAddr[7:0];
        end
        pc    = 16'h0200 + 16'($urandom % 32'h3000);
        acc   = 8'h00;
        carry = 1'b0;
        mem[16'hFFFC] = pc[7:0];
        mem[16'hFFFD] = pc[15:8];
        expectAccess(16'hFFFC, 1'b0, 8'h00);
        expectAccess(16'hFFFD, 1'b0, 8'h00);
        for (int n = 0; n < NUM_INSTR; n++) begin
            pick = $urandom % 9;
            imm  = 8'($urandom);
            case (pick)
                0: begin
                    codeRead(pc, OP_LDA_IMM);
                    codeRead(pc + 16'd1, imm);
                    acc = imm;
                    pc  = pc + 16'd2;
                end
                1, 2: begin
                    codeRead(pc, OP_ADC_IMM);
                    codeRead(pc + 16'd1, imm);
                    sum   = {1'b0, acc} + {1'b0, imm} + {8'd0, carry};
                    acc   = sum[7:0];
                    carry = sum[8];
                    pc    = pc + 16'd2;
                end
                3: begin
                    target = DATA_BASE + 16'($urandom % 256);
                    codeRead(pc, OP_STA_ABS);
                    codeRead(pc + 16'd1, target[7:0]);
                    codeRead(pc + 16'd2, target[15:8]);
                    expectAccess(target, 1'b1, acc);
                    pc = pc + 16'd3;
                end
                4: begin
                    target = pc + 16'd3 + 16'($urandom % 16); // Skip a small gap.
                    codeRead(pc, OP_JMP_ABS);
                    codeRead(pc + 16'd1, target[7:0]);
                    codeRead(pc + 16'd2, target[15:8]);
                    pc = target;
                end
                default: begin
                    case (pick)
                        5:       codeRead(pc, OP_CLC);
                        6:       codeRead(pc, OP_SEC);
                        7:       codeRead(pc, OP_NOP);
                        default: codeRead(pc, oddOps[$urandom % 4]);
                    endcase
                    if (pick == 5) begin
                        carry = 1'b0;
                    end else if (pick == 6) begin
                        carry = 1'b1;
                    end
                    expectAccess(pc + 16'd1, 1'b0, 8'h00); // Dummy read, PC holds.
                    pc = pc + 16'd1;
                end
            endcase
        end
    endtask

    initial begin
        int unsigned seedResult;
        errors     = 0;
        checks     = 0;
        rst        = 1'b1;
        seedResult = $urandom(SEED);
        buildProgram();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < expAddr.size(); i++) begin
            if (i > 0) begin
                @(negedge clk);
            end
            check("address", expAddr[i], busAddress);
            check("readNotWrite", {15'd0, ~expWrite[i]}, {15'd0, readNotWrite});
            if (expWrite[i]) begin
                check("dataBusGPIO", {8'd0, expData[i]}, {8'd0, dataBusGPIO});
            end else begin
                check("dataBusGPIO", {8'd0, mem[busAddress]}, {8'd0, dataBusGPIO}); // No contention.
            end
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the program did not finish within %0d ns", TIMEOUT_NS);
        $display("Something failed");
        $finish;
    end

endmodule

/* top8227.sv */
`timescale 1ns/10ps

module top8227 (
    input  logic                          clk,
    input  logic                          rst,
    inout  wire  [cpuPkg::DATA_W-1:0]     dataBusGPIO,
    output logic [cpuPkg::DATA_W-1:0]     AddressBusHigh,
    output logic [cpuPkg::DATA_W-1:0]     AddressBusLow,
    output logic                          readNotWrite
);
    import cpuPkg::*;

    logic [DATA_W-1:0]   dataBusInput;
    logic [DATA_W-1:0]   dataBusOutput;
    logic [DATA_W-1:0]   opcodeCurrentValue;
    logic                resetRunning;
    logic                resetStep;
    logic [NUMFLAGS-1:0] flags;

    assign readNotWrite = ~flags[SET_WRITE_FLAG];
    assign dataBusInput = dataBusGPIO;
    assign dataBusGPIO  = readNotWrite ? 'z : dataBusOutput; // Drive only on STA.

    instructionLoader u_instructionLoader (
        .clk(clk),
        .rst(rst),
        .flags(flags),
        .externalDB(dataBusInput),
        .nextInstruction(opcodeCurrentValue),
        .resetRunning(resetRunning),
        .resetStep(resetStep)
    );

    internalDataflow u_internalDataflow (
        .clk(clk),
        .rst(rst),
        .flags(flags),
        .resetRunning(resetRunning),
        .resetStep(resetStep),
        .externalDBRead(dataBusInput),
        .externalDBWrite(dataBusOutput),
        .externalAddressBusLowOutput(AddressBusLow),
        .externalAddressBusHighOutput(AddressBusHigh)
    );

    sequencer u_sequencer (
        .clk(clk),
        .rst(rst),
        .resetRunning(resetRunning),
        .opcode(opcodeCurrentValue),
        .outflags(flags)
    );

endmodule

/* sequencer.sv */
`timescale 1ns/10ps

module sequencer (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          resetRunning,
    input  logic [cpuPkg::DATA_W-1:0]     opcode,
    output logic [cpuPkg::NUMFLAGS-1:0]   outflags
);
    import cpuPkg::*;

    cycleT  state;
    cycleT  stateNext;
    opcodeT op;

    assign op = opcodeT'(opcode);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= T_FETCH;
        end else begin
            state <= stateNext;
        end
    end

    always_comb begin
        outflags  = '0;
        stateNext = T_FETCH;
        if (!resetRunning) begin
            case (state)
                T_FETCH: begin
                    outflags[PC_INC_FLAG]      = 1'b1;
                    outflags[LOAD_OPCODE_FLAG] = 1'b1;
                    stateNext                  = T_OP1;
                end
                T_OP1: begin
                    case (op)
                        OP_LDA_IMM: begin
                            outflags[PC_INC_FLAG]   = 1'b1;
                            outflags[LOAD_ACC_FLAG] = 1'b1;
                        end
                        OP_ADC_IMM: begin
                            outflags[PC_INC_FLAG] = 1'b1;
                            outflags[ADD_FLAG]    = 1'b1;
                        end
                        OP_CLC: begin
                            outflags[CLR_CARRY_FLAG] = 1'b1; // Dummy read, PC holds.
                        end
                        OP_SEC: begin
                            outflags[SET_CARRY_FLAG] = 1'b1;
                        end
                        OP_STA_ABS, OP_JMP_ABS: begin
                            outflags[PC_INC_FLAG]    = 1'b1;
                            outflags[LATCH_ADL_FLAG] = 1'b1;
                            stateNext                = T_OP2;
                        end
                        default: begin
                            stateNext = T_FETCH; // NOP and anything unknown.
                        end
                    endcase
                end
                T_OP2: begin
                    case (op)
                        OP_STA_ABS: begin
                            outflags[PC_INC_FLAG]    = 1'b1;
                            outflags[LATCH_ADH_FLAG] = 1'b1;
                            stateNext                = T_EXEC;
                        end
                        OP_JMP_ABS: begin
                            outflags[LATCH_ADH_FLAG] = 1'b1; // PC takes the target.
                        end
                        default: begin
                            stateNext = T_FETCH;
                        end
                    endcase
                end
                T_EXEC: begin
                    if (op == OP_STA_ABS) begin
                        outflags[ADDR_FROM_LATCH_FLAG] = 1'b1;
                        outflags[SET_WRITE_FLAG]       = 1'b1;
                    end
                end
                default: begin
                    stateNext = T_FETCH;
                end
            endcase
        end
    end

    // Writes only at the end of a full STA sequence.
    assert property (@(posedge clk) disable iff (rst || resetRunning)
        outflags[SET_WRITE_FLAG] |-> $past(op, 2) == OP_STA_ABS)
        else $error("Write outside the STA store cycle");

endmodule

/* internalDataflow.sv */
`timescale 1ns/10ps

module internalDataflow (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [cpuPkg::NUMFLAGS-1:0]   flags,
    input  logic                          resetRunning,
    input  logic                          resetStep,
    input  logic [cpuPkg::DATA_W-1:0]     externalDBRead,
    output logic [cpuPkg::DATA_W-1:0]     externalDBWrite,
    output logic [cpuPkg::DATA_W-1:0]     externalAddressBusLowOutput,
    output logic [cpuPkg::DATA_W-1:0]     externalAddressBusHighOutput
);
    import cpuPkg::*;

    logic [ADDR_W-1:0] programCounter;
    logic [DATA_W-1:0] accumulator;
    logic              carryFlag;
    logic [DATA_W-1:0] addressLatchLow;
    logic [DATA_W-1:0] addressLatchHigh;

    logic [DATA_W-1:0] aluSum;
    logic              aluCarryOut;
    logic              jumpTaken;
    logic [ADDR_W-1:0] addressOut;

    // ALU, with its own carry path into the status bit.
    assign {aluCarryOut, aluSum} = {1'b0, accumulator}
                                 + {1'b0, externalDBRead}
                                 + {{DATA_W{1'b0}}, carryFlag};

    // High address byte read without a PC step is the JMP target cycle.
    assign jumpTaken = flags[LATCH_ADH_FLAG] & ~flags[PC_INC_FLAG];

    always_ff @(posedge clk) begin
        if (rst) begin
            programCounter <= '0;
        end else if (resetRunning) begin
            if (resetStep) begin
                programCounter[ADDR_W-1:DATA_W] <= externalDBRead;
            end else begin
                programCounter[DATA_W-1:0] <= externalDBRead;
            end
        end else if (jumpTaken) begin
            programCounter <= {externalDBRead, addressLatchLow}; // High byte straight off the bus.
        end else if (flags[PC_INC_FLAG]) begin
            programCounter <= programCounter + 16'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            accumulator <= '0;
        end else if (flags[LOAD_ACC_FLAG]) begin
            accumulator <= externalDBRead;
        end else if (flags[ADD_FLAG]) begin
            accumulator <= aluSum;
        end
    end

    // Only the carry bit of the status register exists.
    always_ff @(posedge clk) begin
        if (rst) begin
            carryFlag <= 1'b0;
        end else if (flags[ADD_FLAG]) begin
            carryFlag <= aluCarryOut;
        end else if (flags[SET_CARRY_FLAG]) begin
            carryFlag <= 1'b1;
        end else if (flags[CLR_CARRY_FLAG]) begin
            carryFlag <= 1'b0;
        end
    end

    // Operand address latch.
    always_ff @(posedge clk) begin
        if (flags[LATCH_ADL_FLAG]) begin
            addressLatchLow <= externalDBRead;
        end
        if (flags[LATCH_ADH_FLAG]) begin
            addressLatchHigh <= externalDBRead;
        end
    end

    always_comb begin
        if (resetRunning) begin
            addressOut = RESET_VECTOR | {{(ADDR_W-1){1'b0}}, resetStep};
        end else if (flags[ADDR_FROM_LATCH_FLAG]) begin
            addressOut = {addressLatchHigh, addressLatchLow};
        end else begin
            addressOut = programCounter;
        end
    end

    assign externalAddressBusLowOutput  = addressOut[DATA_W-1:0];
    assign externalAddressBusHighOutput = addressOut[ADDR_W-1:DATA_W];
    assign externalDBWrite              = accumulator; // STA is the only writer.

    assert property (@(posedge clk) disable iff (rst)
        !(flags[SET_CARRY_FLAG] && flags[CLR_CARRY_FLAG]))
        else $error("Carry set and cleared in the same cycle");

    // A store address needs both latch bytes written first.
    assert property (@(posedge clk) disable iff (rst || resetRunning)
        flags[ADDR_FROM_LATCH_FLAG] |-> $past(flags[LATCH_ADH_FLAG])
                                      && $past(flags[LATCH_ADL_FLAG], 2))
        else $error("Latched address used before it was loaded");

endmodule

/* instructionLoader.sv */
`timescale 1ns/10ps

module instructionLoader (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [cpuPkg::NUMFLAGS-1:0]   flags,
    input  logic [cpuPkg::DATA_W-1:0]     externalDB,
    output logic [cpuPkg::DATA_W-1:0]     nextInstruction,
    output logic                          resetRunning,
    output logic                          resetStep
);
    import cpuPkg::*;

    // Opcode register.
    always_ff @(posedge clk) begin
        if (rst) begin
            nextInstruction <= OP_NOP;
        end else if (flags[LOAD_OPCODE_FLAG]) begin
            nextInstruction <= externalDB;
        end
    end

    // Two reads after reset, vector low then vector high.
    always_ff @(posedge clk) begin
        if (rst) begin
            resetRunning <= 1'b1;
            resetStep    <= 1'b0;
        end else if (resetRunning) begin
            if (resetStep) begin
                resetRunning <= 1'b0; // High byte read this cycle.
            end
            resetStep <= ~resetStep;
        end
    end

    // The sequencer must stay idle until the vector is in the PC.
    assert property (@(posedge clk) disable iff (rst)
        flags[LOAD_OPCODE_FLAG] |-> !resetRunning)
        else $error("Opcode loaded during the reset sequence");

endmodule

/* cpuPkg.sv */
package cpuPkg;

    localparam int DATA_W = 8;
    localparam int ADDR_W = 16;

    localparam logic [ADDR_W-1:0] RESET_VECTOR = 16'hFFFC; // Low byte, high byte at +1.

    localparam int NUMFLAGS = 10;

    // Bit positions in the control flag vector.
    localparam int PC_INC_FLAG          = 0;
    localparam int LOAD_OPCODE_FLAG     = 1;
    localparam int LOAD_ACC_FLAG        = 2;
    localparam int ADD_FLAG             = 3;
    localparam int SET_CARRY_FLAG       = 4;
    localparam int CLR_CARRY_FLAG       = 5;
    localparam int LATCH_ADL_FLAG       = 6;
    localparam int LATCH_ADH_FLAG       = 7; // Without PC_INC this is a jump.
    localparam int ADDR_FROM_LATCH_FLAG = 8;
    localparam int SET_WRITE_FLAG       = 9;

    typedef enum logic [7:0] {
        OP_LDA_IMM = 8'hA9,
        OP_ADC_IMM = 8'h69,
        OP_STA_ABS = 8'h8D,
        OP_JMP_ABS = 8'h4C,
        OP_CLC     = 8'h18,
        OP_SEC     = 8'h38,
        OP_NOP     = 8'hEA
    } opcodeT;

    typedef enum logic [1:0] {
        T_FETCH = 2'd0, // Opcode read at PC.
        T_OP1   = 2'd1, // Immediate, dummy or address-low read.
        T_OP2   = 2'd2, // Address-high read.
        T_EXEC  = 2'd3  // Store cycle.
    } cycleT;

endpackage
